// ==== src/rv32_macros.svh ====
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

`define XLEN          32
`define REG_AW        5

// alu operation codes
`define ALUOP_LEN     5
`define ALUOP_ADD     5'd1
`define ALUOP_SUB     5'd2
`define ALUOP_XOR     5'd3
`define ALUOP_OR      5'd4
`define ALUOP_AND     5'd5
`define ALUOP_SLL     5'd6
`define ALUOP_SRL     5'd7
`define ALUOP_SRA     5'd8
`define ALUOP_SLT     5'd9
`define ALUOP_SLTU    5'd10
`define ALUOP_BEQ     5'd11
`define ALUOP_BNE     5'd12
`define ALUOP_BLT     5'd13
`define ALUOP_BGE     5'd14
`define ALUOP_BLTU    5'd15
`define ALUOP_BGEU    5'd16

// memory operation codes, none must stay zero
`define MEMOP_LEN     4
`define MEMOP_NONE    4'd0
`define MEMOP_LB      4'd1
`define MEMOP_LH      4'd2
`define MEMOP_LW      4'd3
`define MEMOP_LBU     4'd4
`define MEMOP_LHU     4'd5
`define MEMOP_SB      4'd6
`define MEMOP_SH      4'd7
`define MEMOP_SW      4'd8

// execute classes
`define EXCOP_LEN     4
`define EXCOP_NONE    4'd0
`define EXCOP_LUI     4'd1
`define EXCOP_AUIPC   4'd2
`define EXCOP_JAL     4'd3
`define EXCOP_JALR    4'd4
`define EXCOP_LOAD    4'd5
`define EXCOP_STORE   4'd6
`define EXCOP_BRANCH  4'd7
`define EXCOP_OPIMM   4'd8
`define EXCOP_OPREG   4'd9
`define EXCOP_EBREAK  4'd10

// trap bus bit positions
`define TRAP_LEN      8
`define TRAP_ECALL    0
`define TRAP_EBREAK   1
`define TRAP_MRET     2
`define TRAP_ILLEGAL  3

// major opcodes
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_OPIMM     7'b0010011
`define OPC_OPREG     7'b0110011

// match masks and fixed system encodings
`define MASK_OPCODE   32'h0000_007f
`define MASK_FUNC3    32'h0000_707f
`define MASK_FUNC7    32'hfe00_707f
`define INST_ECALL    32'h0000_0073
`define INST_EBREAK   32'h0010_0073
`define INST_MRET     32'h3020_0073

`endif

// ==== src/decode_pkg.sv ====
`include "rv32_macros.svh"

package decode_pkg;

  // field layouts of the base formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, read per format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  // one-hot immediate format
  typedef struct packed {
    logic fmt_none;
    logic fmt_i;
    logic fmt_s;
    logic fmt_b;
    logic fmt_u;
    logic fmt_j;
  } imm_sel_t;

  typedef struct packed {
    logic [`ALUOP_LEN-1:0] alu_op;
    logic [`MEMOP_LEN-1:0] mem_op;
    logic [`EXCOP_LEN-1:0] exc_op;
    imm_sel_t              imm_sel;
    logic                  need_rs1;
    logic                  need_rs2;
    logic                  need_rd;
    logic                  is_call;
    logic                  ecall;
    logic                  ebreak;
    logic                  mret;
    logic                  illegal;
  } dec_ctrl_t;

  typedef struct packed {
    logic                  valid;
    logic [`XLEN-1:0]      pc;
    logic [`REG_AW-1:0]    rs1_idx;
    logic [`REG_AW-1:0]    rs2_idx;
    logic [`REG_AW-1:0]    rd_idx;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;
    logic [`XLEN-1:0]      imm;
    logic [`ALUOP_LEN-1:0] alu_op;
    logic [`MEMOP_LEN-1:0] mem_op;
    logic [`EXCOP_LEN-1:0] exc_op;
    logic [`TRAP_LEN-1:0]  trap_bus;
    logic                  is_call;
  } id_ex_t;

endpackage

// ==== src/inst_classifier.sv ====
`timescale 1ns/10ps
`include "rv32_macros.svh"

module inst_classifier (
  input  decode_pkg::inst_u     inst_i,
  input  logic [`TRAP_LEN-1:0]  trap_bus_i,
  output decode_pkg::dec_ctrl_t ctrl_o,
  output logic [`TRAP_LEN-1:0]  trap_bus_o
);

  logic [31:0] word;
  logic [2:0]  f3;
  logic        lui, auipc, jal, jalr, branch, load, store;
  logic        op_imm, op_reg, ecall, ebreak, mret, system, illegal;
  logic        fmt_i, fmt_s, fmt_b, fmt_u, fmt_j;

  function automatic logic hit(input logic [31:0] w, input logic [31:0] mask,
                               input logic [31:0] val);
    return (w & mask) == val;
  endfunction

  assign word = inst_i;
  assign f3   = inst_i.r.funct3;

  assign lui    = hit(word, `MASK_OPCODE, {25'b0, `OPC_LUI});
  assign auipc  = hit(word, `MASK_OPCODE, {25'b0, `OPC_AUIPC});
  assign jal    = hit(word, `MASK_OPCODE, {25'b0, `OPC_JAL});
  assign jalr   = hit(word, `MASK_FUNC3, {17'b0, 3'b000, 5'b0, `OPC_JALR});
  // funct3 010 and 011 are holes in the branch space
  assign branch = hit(word, `MASK_OPCODE, {25'b0, `OPC_BRANCH}) &&
                  f3 != 3'b010 && f3 != 3'b011;
  assign load   = hit(word, `MASK_OPCODE, {25'b0, `OPC_LOAD}) &&
                  f3 != 3'b011 && f3 < 3'b110;
  assign store  = hit(word, `MASK_OPCODE, {25'b0, `OPC_STORE}) && f3 < 3'b011;

  // shift immediates also pin funct7
  assign op_imm = (hit(word, `MASK_OPCODE, {25'b0, `OPC_OPIMM}) &&
                   f3 != 3'b001 && f3 != 3'b101) ||
                  hit(word, `MASK_FUNC7, {7'h00, 10'b0, 3'b001, 5'b0, `OPC_OPIMM}) ||
                  hit(word, `MASK_FUNC7, {7'h00, 10'b0, 3'b101, 5'b0, `OPC_OPIMM}) ||
                  hit(word, `MASK_FUNC7, {7'h20, 10'b0, 3'b101, 5'b0, `OPC_OPIMM});
  // funct7 0x20 only for sub and sra
  assign op_reg = hit(word, `MASK_FUNC7, {7'h00, 10'b0, f3, 5'b0, `OPC_OPREG}) ||
                  (hit(word, `MASK_FUNC7, {7'h20, 10'b0, f3, 5'b0, `OPC_OPREG}) &&
                   (f3 == 3'b000 || f3 == 3'b101));

  assign ecall   = (word == `INST_ECALL);
  assign ebreak  = (word == `INST_EBREAK);
  assign mret    = (word == `INST_MRET);
  assign system  = ecall | ebreak | mret;
  assign illegal = ~(lui | auipc | jal | jalr | branch | load | store |
                     op_imm | op_reg | system);

  assign fmt_i = load | op_imm | jalr | system;
  assign fmt_s = store;
  assign fmt_b = branch;
  assign fmt_u = lui | auipc;
  assign fmt_j = jal;

  always_comb begin
    ctrl_o = '0;
    ctrl_o.imm_sel  = '{fmt_none: ~(fmt_i | fmt_s | fmt_b | fmt_u | fmt_j),
                        fmt_i: fmt_i, fmt_s: fmt_s, fmt_b: fmt_b,
                        fmt_u: fmt_u, fmt_j: fmt_j};
    ctrl_o.need_rs1 = op_reg | fmt_i | fmt_s | fmt_b;
    ctrl_o.need_rs2 = op_reg | fmt_s | fmt_b;
    ctrl_o.need_rd  = op_reg | fmt_i | fmt_u | fmt_j;
    ctrl_o.is_call  = (jal | jalr) && inst_i.j.rd != '0;
    ctrl_o.ecall    = ecall;
    ctrl_o.ebreak   = ebreak;
    ctrl_o.mret     = mret;
    ctrl_o.illegal  = illegal;

    // address math and upper immediates all use add
    ctrl_o.alu_op = `ALUOP_ADD;
    if (branch) begin
      case (f3)
        3'b000:  ctrl_o.alu_op = `ALUOP_BEQ;
        3'b001:  ctrl_o.alu_op = `ALUOP_BNE;
        3'b100:  ctrl_o.alu_op = `ALUOP_BLT;
        3'b101:  ctrl_o.alu_op = `ALUOP_BGE;
        3'b110:  ctrl_o.alu_op = `ALUOP_BLTU;
        default: ctrl_o.alu_op = `ALUOP_BGEU;
      endcase
    end else if (op_imm || op_reg) begin
      case (f3)
        3'b000:  ctrl_o.alu_op = (op_reg && inst_i.r.funct7[5]) ? `ALUOP_SUB : `ALUOP_ADD;
        3'b001:  ctrl_o.alu_op = `ALUOP_SLL;
        3'b010:  ctrl_o.alu_op = `ALUOP_SLT;
        3'b011:  ctrl_o.alu_op = `ALUOP_SLTU;
        3'b100:  ctrl_o.alu_op = `ALUOP_XOR;
        3'b101:  ctrl_o.alu_op = inst_i.r.funct7[5] ? `ALUOP_SRA : `ALUOP_SRL;
        3'b110:  ctrl_o.alu_op = `ALUOP_OR;
        default: ctrl_o.alu_op = `ALUOP_AND;
      endcase
    end

    ctrl_o.mem_op = `MEMOP_NONE;
    if (load) begin
      case (f3)
        3'b000:  ctrl_o.mem_op = `MEMOP_LB;
        3'b001:  ctrl_o.mem_op = `MEMOP_LH;
        3'b010:  ctrl_o.mem_op = `MEMOP_LW;
        3'b100:  ctrl_o.mem_op = `MEMOP_LBU;
        default: ctrl_o.mem_op = `MEMOP_LHU;
      endcase
    end else if (store) begin
      case (f3)
        3'b000:  ctrl_o.mem_op = `MEMOP_SB;
        3'b001:  ctrl_o.mem_op = `MEMOP_SH;
        default: ctrl_o.mem_op = `MEMOP_SW;
      endcase
    end

    // ecall and mret keep class none and travel on the trap bus
    if (lui)         ctrl_o.exc_op = `EXCOP_LUI;
    else if (auipc)  ctrl_o.exc_op = `EXCOP_AUIPC;
    else if (jal)    ctrl_o.exc_op = `EXCOP_JAL;
    else if (jalr)   ctrl_o.exc_op = `EXCOP_JALR;
    else if (load)   ctrl_o.exc_op = `EXCOP_LOAD;
    else if (store)  ctrl_o.exc_op = `EXCOP_STORE;
    else if (branch) ctrl_o.exc_op = `EXCOP_BRANCH;
    else if (op_imm) ctrl_o.exc_op = `EXCOP_OPIMM;
    else if (op_reg) ctrl_o.exc_op = `EXCOP_OPREG;
    else if (ebreak) ctrl_o.exc_op = `EXCOP_EBREAK;
    else             ctrl_o.exc_op = `EXCOP_NONE;
  end

  // decode owns four trap positions and fetch owns the rest
  always_comb begin
    trap_bus_o                = trap_bus_i;
    trap_bus_o[`TRAP_ECALL]   = ctrl_o.ecall;
    trap_bus_o[`TRAP_EBREAK]  = ctrl_o.ebreak;
    trap_bus_o[`TRAP_MRET]    = ctrl_o.mret;
    trap_bus_o[`TRAP_ILLEGAL] = ctrl_o.illegal;
  end

endmodule

// ==== src/imm_gen.sv ====
`timescale 1ns/10ps
`include "rv32_macros.svh"

module imm_gen (
  input  decode_pkg::inst_u    inst_i,
  input  decode_pkg::imm_sel_t imm_sel_i,
  output logic [`XLEN-1:0]     imm_o
);

  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign imm_i = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
  assign imm_s = {{20{inst_i.s.imm_11_5[6]}}, inst_i.s.imm_11_5, inst_i.s.imm_4_0};
  // b and j scatter their bits, lsb is always zero
  assign imm_b = {{19{inst_i.b.imm_12}}, inst_i.b.imm_12, inst_i.b.imm_11,
                  inst_i.b.imm_10_5, inst_i.b.imm_4_1, 1'b0};
  assign imm_u = {inst_i.u.imm_31_12, 12'b0};
  assign imm_j = {{11{inst_i.j.imm_20}}, inst_i.j.imm_20, inst_i.j.imm_19_12,
                  inst_i.j.imm_11, inst_i.j.imm_10_1, 1'b0};

  always_comb begin
    case (1'b1)
      imm_sel_i.fmt_none: imm_o = '0;
      imm_sel_i.fmt_i:    imm_o = imm_i;
      imm_sel_i.fmt_s:    imm_o = imm_s;
      imm_sel_i.fmt_b:    imm_o = imm_b;
      imm_sel_i.fmt_u:    imm_o = imm_u;
      imm_sel_i.fmt_j:    imm_o = imm_j;
      default:            imm_o = '0;
    endcase
  end

endmodule

// ==== src/operand_bypass.sv ====
`timescale 1ns/10ps
`include "rv32_macros.svh"

module operand_bypass (
  input  logic [`REG_AW-1:0] rs1_idx_i,
  input  logic [`REG_AW-1:0] rs2_idx_i,
  input  logic [`XLEN-1:0]   rs1_data_i,
  input  logic [`XLEN-1:0]   rs2_data_i,
  input  decode_pkg::id_ex_t ex_entry_i,
  input  logic [`XLEN-1:0]   ex_rd_data_i,
  input  logic [`REG_AW-1:0] mem_rd_addr_i,
  input  logic [`XLEN-1:0]   mem_rd_data_i,
  output logic [`XLEN-1:0]   rs1_o,
  output logic [`XLEN-1:0]   rs2_o,
  output logic               load_use_o
);

  logic rs1_ex_hit, rs2_ex_hit, ex_is_load;

  // x0 never forwards
  function automatic logic same_reg(input logic [`REG_AW-1:0] src,
                                    input logic [`REG_AW-1:0] dst);
    return src != '0 && src == dst;
  endfunction

  // priority ex, then mem, then register file
  function automatic logic [`XLEN-1:0] pick(input logic ex_hit,
                                            input logic [`REG_AW-1:0] idx,
                                            input logic [`XLEN-1:0] rf_data);
    if (ex_hit) return ex_rd_data_i;
    if (same_reg(idx, mem_rd_addr_i)) return mem_rd_data_i;
    return rf_data;
  endfunction

  assign rs1_ex_hit = same_reg(rs1_idx_i, ex_entry_i.rd_idx);
  assign rs2_ex_hit = same_reg(rs2_idx_i, ex_entry_i.rd_idx);
  assign rs1_o      = pick(rs1_ex_hit, rs1_idx_i, rs1_data_i);
  assign rs2_o      = pick(rs2_ex_hit, rs2_idx_i, rs2_data_i);

  // load data only exists after mem, so ex result is not usable yet
  assign ex_is_load = ex_entry_i.valid && ex_entry_i.exc_op == `EXCOP_LOAD;
  assign load_use_o = ex_is_load && (rs1_ex_hit || rs2_ex_hit);

endmodule

// ==== src/id_ex_reg.sv ====
`timescale 1ns/10ps
`include "rv32_macros.svh"

module id_ex_reg (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  input  logic                  flush_i,
  input  logic                  stall_i,
  input  logic [`XLEN-1:0]      pc_i,
  input  decode_pkg::dec_ctrl_t ctrl_i,
  input  logic [`TRAP_LEN-1:0]  trap_bus_i,
  input  logic [`REG_AW-1:0]    rs1_idx_i,
  input  logic [`REG_AW-1:0]    rs2_idx_i,
  input  logic [`REG_AW-1:0]    rd_idx_i,
  input  logic [`XLEN-1:0]      rs1_i,
  input  logic [`XLEN-1:0]      rs2_i,
  input  logic [`XLEN-1:0]      imm_i,
  output decode_pkg::id_ex_t    entry_o,
  output logic                  ras_push_valid_o,
  output logic [`XLEN-1:0]      ras_push_data_o
);

  decode_pkg::id_ex_t entry_d, entry_q;
  logic               accept;

  assign accept = valid_i && !stall_i && !flush_i;

  always_comb begin
    entry_d = '{valid: 1'b1, pc: pc_i, rs1_idx: rs1_idx_i, rs2_idx: rs2_idx_i,
                rd_idx: rd_idx_i, rs1_data: rs1_i, rs2_data: rs2_i, imm: imm_i,
                alu_op: ctrl_i.alu_op, mem_op: ctrl_i.mem_op, exc_op: ctrl_i.exc_op,
                trap_bus: trap_bus_i, is_call: ctrl_i.is_call};
    // bubble: kill every field that causes a side effect downstream
    if (!accept) begin
      entry_d.valid    = 1'b0;
      entry_d.rd_idx   = '0;
      entry_d.exc_op   = `EXCOP_NONE;
      entry_d.mem_op   = `MEMOP_NONE;
      entry_d.trap_bus = '0;
      entry_d.is_call  = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      entry_q <= '0;
    end else begin
      entry_q <= entry_d;
    end
  end

  assign entry_o          = entry_q;
  assign ras_push_valid_o = entry_q.valid && entry_q.is_call;
  assign ras_push_data_o  = entry_q.pc + `XLEN'd4;

  a_flush_bubble: assert property (@(posedge clk) disable iff (!arst_n_i)
    flush_i |=> !entry_q.valid && entry_q.trap_bus == '0 && entry_q.rd_idx == '0)
    else $error("flush did not leave a bubble");

  a_stall_bubble: assert property (@(posedge clk) disable iff (!arst_n_i)
    stall_i |=> !entry_q.valid && entry_q.mem_op == `MEMOP_NONE)
    else $error("stall did not leave a bubble");

  // call flag comes from the classifier, class from the same word
  a_push_is_jump: assert property (@(posedge clk) disable iff (!arst_n_i)
    ras_push_valid_o |-> entry_q.exc_op inside {`EXCOP_JAL, `EXCOP_JALR})
    else $error("return stack push from a non-jump entry");

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/10ps
`include "rv32_macros.svh"

module decode_stage (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 valid_i,
  input  logic [`XLEN-1:0]     inst_addr_i,
  input  logic [`XLEN-1:0]     inst_data_i,
  input  logic [`TRAP_LEN-1:0] trap_bus_i,
  input  logic [`XLEN-1:0]     rs1_data_i,
  input  logic [`XLEN-1:0]     rs2_data_i,
  input  logic [`XLEN-1:0]     ex_rd_data_i,
  input  logic [`REG_AW-1:0]   mem_rd_addr_i,
  input  logic [`XLEN-1:0]     mem_rd_data_i,
  input  logic                 flush_i,
  output logic [`REG_AW-1:0]   rs1_idx_o,
  output logic [`REG_AW-1:0]   rs2_idx_o,
  output logic                 stall_o,
  output decode_pkg::id_ex_t   id_ex_o,
  output logic                 ras_push_valid_o,
  output logic [`XLEN-1:0]     ras_push_data_o
);

  decode_pkg::inst_u     inst;
  decode_pkg::dec_ctrl_t ctrl;
  logic [`TRAP_LEN-1:0]  trap_bus;
  logic [`REG_AW-1:0]    rs1_idx, rs2_idx, rd_idx;
  logic [`XLEN-1:0]      imm, rs1_fwd, rs2_fwd;
  logic                  load_use;

  assign inst = inst_data_i;

  // unused index fields read as x0
  assign rs1_idx = ctrl.need_rs1 ? inst.r.rs1 : '0;
  assign rs2_idx = ctrl.need_rs2 ? inst.r.rs2 : '0;
  assign rd_idx  = ctrl.need_rd ? inst.r.rd : '0;

  assign rs1_idx_o = rs1_idx;
  assign rs2_idx_o = rs2_idx;
  assign stall_o   = load_use;

  inst_classifier u_classifier (
    .inst_i(inst), .trap_bus_i(trap_bus_i), .ctrl_o(ctrl), .trap_bus_o(trap_bus)
  );

  imm_gen u_imm_gen (.inst_i(inst), .imm_sel_i(ctrl.imm_sel), .imm_o(imm));

  operand_bypass u_bypass (
    .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx),
    .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
    .ex_entry_i(id_ex_o), .ex_rd_data_i(ex_rd_data_i),
    .mem_rd_addr_i(mem_rd_addr_i), .mem_rd_data_i(mem_rd_data_i),
    .rs1_o(rs1_fwd), .rs2_o(rs2_fwd), .load_use_o(load_use)
  );

  id_ex_reg u_id_ex (
    .clk(clk), .arst_n_i(arst_n_i), .valid_i(valid_i), .flush_i(flush_i),
    .stall_i(load_use), .pc_i(inst_addr_i), .ctrl_i(ctrl), .trap_bus_i(trap_bus),
    .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx), .rd_idx_i(rd_idx),
    .rs1_i(rs1_fwd), .rs2_i(rs2_fwd), .imm_i(imm),
    .entry_o(id_ex_o), .ras_push_valid_o(ras_push_valid_o),
    .ras_push_data_o(ras_push_data_o)
  );

endmodule

// ==== verification/decode_stage_tb.sv ====
`timescale 1ns/10ps
`include "rv32_macros.svh"

module decode_stage_tb;

  // format codes for the reference model
  // R has no immediate but uses all three registers
  localparam logic [2:0] F_NONE = 3'd0;
  localparam logic [2:0] F_I    = 3'd1;
  localparam logic [2:0] F_S    = 3'd2;
  localparam logic [2:0] F_B    = 3'd3;
  localparam logic [2:0] F_U    = 3'd4;
  localparam logic [2:0] F_J    = 3'd5;
  localparam logic [2:0] F_R    = 3'd6;

  // lookup by funct3
  // zero or none marks an encoding hole
  localparam logic [4:0] BR_ALU [8] = '{`ALUOP_BEQ, `ALUOP_BNE, 5'd0, 5'd0,
                                        `ALUOP_BLT, `ALUOP_BGE, `ALUOP_BLTU, `ALUOP_BGEU};
  localparam logic [4:0] OP_ALU [8] = '{`ALUOP_ADD, `ALUOP_SLL, `ALUOP_SLT, `ALUOP_SLTU,
                                        `ALUOP_XOR, `ALUOP_SRL, `ALUOP_OR, `ALUOP_AND};
  localparam logic [3:0] LD_MEM [8] = '{`MEMOP_LB, `MEMOP_LH, `MEMOP_LW, `MEMOP_NONE,
                                        `MEMOP_LBU, `MEMOP_LHU, `MEMOP_NONE, `MEMOP_NONE};
  localparam logic [3:0] ST_MEM [8] = '{`MEMOP_SB, `MEMOP_SH, `MEMOP_SW, `MEMOP_NONE,
                                        `MEMOP_NONE, `MEMOP_NONE, `MEMOP_NONE, `MEMOP_NONE};

  typedef struct packed {
    logic [2:0] fmt;
    logic [4:0] alu;
    logic [3:0] mem;
    logic [3:0] exc;
    logic       ok;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
  } ref_t;

  logic               clk = 1'b0;
  logic               arst_n;
  logic               valid;
  logic               flush;
  logic [31:0]        inst_addr;
  logic [31:0]        inst_data;
  logic [7:0]         trap_in;
  logic [31:0]        rs1_data;
  logic [31:0]        rs2_data;
  logic [31:0]        ex_data;
  logic [4:0]         mem_rd_addr;
  logic [31:0]        mem_rd_data;
  logic [4:0]         rs1_idx;
  logic [4:0]         rs2_idx;
  logic               stall;
  decode_pkg::id_ex_t id_ex;
  logic               push_valid;
  logic [31:0]        push_data;

  decode_pkg::id_ex_t exp_q;
  ref_t               cur;
  logic               exp_stall;
  logic [31:0]        lcg_state;
  logic [31:0]        pc;
  int                 errors;
  int                 timeouts;

  always #5 clk = ~clk;

  decode_stage dut0 (
    .clk(clk), .arst_n_i(arst_n), .valid_i(valid), .inst_addr_i(inst_addr),
    .inst_data_i(inst_data), .trap_bus_i(trap_in), .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data), .ex_rd_data_i(ex_data), .mem_rd_addr_i(mem_rd_addr),
    .mem_rd_data_i(mem_rd_data), .flush_i(flush), .rs1_idx_o(rs1_idx),
    .rs2_idx_o(rs2_idx), .stall_o(stall), .id_ex_o(id_ex),
    .ras_push_valid_o(push_valid), .ras_push_data_o(push_data)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic ref_t mk(input logic [2:0] f, input logic [4:0] a,
                              input logic [3:0] m, input logic [3:0] x);
    return '{fmt: f, alu: a, mem: m, exc: x, ok: 1'b1, default: '0};
  endfunction

  // sub and sra are the only alternate funct7 forms
  function automatic logic [4:0] alu_for(input logic [2:0] f3, input logic alt);
    if (alt && f3 == 3'b000) return `ALUOP_SUB;
    if (alt && f3 == 3'b101) return `ALUOP_SRA;
    return OP_ALU[f3];
  endfunction

  function automatic ref_t ref_decode(input logic [31:0] w);
    ref_t       r;
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    r = '{fmt: F_NONE, alu: `ALUOP_ADD, default: '0};
    case (w[6:0])
      `OPC_LUI:   r = mk(F_U, `ALUOP_ADD, `MEMOP_NONE, `EXCOP_LUI);
      `OPC_AUIPC: r = mk(F_U, `ALUOP_ADD, `MEMOP_NONE, `EXCOP_AUIPC);
      `OPC_JAL:   r = mk(F_J, `ALUOP_ADD, `MEMOP_NONE, `EXCOP_JAL);
      `OPC_JALR:
        if (f3 == 3'b000) r = mk(F_I, `ALUOP_ADD, `MEMOP_NONE, `EXCOP_JALR);
      `OPC_BRANCH:
        if (BR_ALU[f3] != 5'd0) r = mk(F_B, BR_ALU[f3], `MEMOP_NONE, `EXCOP_BRANCH);
      `OPC_LOAD:
        if (LD_MEM[f3] != `MEMOP_NONE) r = mk(F_I, `ALUOP_ADD, LD_MEM[f3], `EXCOP_LOAD);
      `OPC_STORE:
        if (ST_MEM[f3] != `MEMOP_NONE) r = mk(F_S, `ALUOP_ADD, ST_MEM[f3], `EXCOP_STORE);
      `OPC_OPIMM:
        if (f3 == 3'b001 ? f7 == 7'h00 :
            f3 == 3'b101 ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1)
          r = mk(F_I, alu_for(f3, f3 == 3'b101 && f7 == 7'h20), `MEMOP_NONE, `EXCOP_OPIMM);
      `OPC_OPREG:
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)))
          r = mk(F_R, alu_for(f3, f7 == 7'h20), `MEMOP_NONE, `EXCOP_OPREG);
      default: begin
        if (w == `INST_ECALL || w == `INST_MRET)
          r = mk(F_I, `ALUOP_ADD, `MEMOP_NONE, `EXCOP_NONE);
        if (w == `INST_EBREAK)
          r = mk(F_I, `ALUOP_ADD, `MEMOP_NONE, `EXCOP_EBREAK);
      end
    endcase
    r.rs1 = (r.fmt inside {F_I, F_S, F_B, F_R}) ? w[19:15] : 5'd0;
    r.rs2 = (r.fmt inside {F_S, F_B, F_R}) ? w[24:20] : 5'd0;
    r.rd  = (r.fmt inside {F_I, F_U, F_J, F_R}) ? w[11:7] : 5'd0;
    return r;
  endfunction

  function automatic logic [31:0] ref_imm(input logic [31:0] w, input logic [2:0] fmt);
    case (fmt)
      F_I:     return {{20{w[31]}}, w[31:20]};
      F_S:     return {{20{w[31]}}, w[31:25], w[11:7]};
      F_B:     return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      F_U:     return {w[31:12], 12'h000};
      F_J:     return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic ref_stall(input ref_t r, input decode_pkg::id_ex_t prev);
    if (!prev.valid || prev.exc_op != `EXCOP_LOAD || prev.rd_idx == 5'd0) return 1'b0;
    return r.rs1 == prev.rd_idx || r.rs2 == prev.rd_idx;
  endfunction

  function automatic logic [31:0] fwd(input logic [4:0] idx, input logic [31:0] rf,
                                      input logic [4:0] ex_rd);
    if (idx == 5'd0) return rf;
    return (idx == ex_rd) ? ex_data : (idx == mem_rd_addr) ? mem_rd_data : rf;
  endfunction

  // what id_ex_o must hold after the next edge
  function automatic decode_pkg::id_ex_t ref_entry(input decode_pkg::id_ex_t prev);
    decode_pkg::id_ex_t e;
    ref_t               r;
    r = ref_decode(inst_data);
    e = '0;
    if (!valid || flush || ref_stall(r, prev)) return e;
    e.valid    = 1'b1;
    e.pc       = inst_addr;
    e.rs1_idx  = r.rs1;
    e.rs2_idx  = r.rs2;
    e.rd_idx   = r.rd;
    e.rs1_data = fwd(r.rs1, rs1_data, prev.rd_idx);
    e.rs2_data = fwd(r.rs2, rs2_data, prev.rd_idx);
    e.imm      = ref_imm(inst_data, r.fmt);
    e.alu_op   = r.alu;
    e.mem_op   = r.mem;
    e.exc_op   = r.exc;
    e.trap_bus = trap_in;
    e.trap_bus[`TRAP_ECALL]   = inst_data == `INST_ECALL;
    e.trap_bus[`TRAP_EBREAK]  = inst_data == `INST_EBREAK;
    e.trap_bus[`TRAP_MRET]    = inst_data == `INST_MRET;
    e.trap_bus[`TRAP_ILLEGAL] = !r.ok;
    e.is_call  = (r.exc == `EXCOP_JAL || r.exc == `EXCOP_JALR) && inst_data[11:7] != 5'd0;
    return e;
  endfunction

  task automatic note_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    errors++;
  endtask

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_q <= '0;
    end else begin
      exp_q <= ref_entry(exp_q);
    end
  end

  always_comb begin
    cur       = ref_decode(inst_data);
    exp_stall = ref_stall(cur, exp_q);
  end

  a_entry: assert property (@(posedge clk) disable iff (!arst_n)
    exp_q.valid |-> id_ex == exp_q)
    else note_mismatch("id_ex_o differs from the expected entry");

  a_bubble: assert property (@(posedge clk) disable iff (!arst_n)
    !exp_q.valid |-> !id_ex.valid && id_ex.rd_idx == 5'd0 && id_ex.exc_op == `EXCOP_NONE &&
                     id_ex.mem_op == `MEMOP_NONE && id_ex.trap_bus == '0 && !id_ex.is_call)
    else note_mismatch("id_ex_o is not a bubble");

  a_stall: assert property (@(posedge clk) disable iff (!arst_n) stall == exp_stall)
    else note_mismatch("stall_o has the wrong level");

  a_index: assert property (@(posedge clk) disable iff (!arst_n)
    rs1_idx == cur.rs1 && rs2_idx == cur.rs2)
    else note_mismatch("register file indices not gated as expected");

  a_push: assert property (@(posedge clk) disable iff (!arst_n)
    push_valid == (exp_q.valid && exp_q.is_call))
    else note_mismatch("ras_push_valid_o has the wrong level");

  a_push_data: assert property (@(posedge clk) disable iff (!arst_n)
    push_valid |-> push_data == exp_q.pc + 32'd4)
    else note_mismatch("ras_push_data_o is not pc+4");

  function automatic logic [31:0] make_inst(input int k);
    logic [31:0] w;
    logic [31:0] r;
    w = next_rand();
    r = next_rand();
    // small register pool so forwarding and hazards hit often
    w[19:15] = {3'b000, r[1:0]};
    w[24:20] = {3'b000, r[3:2]};
    w[11:7]  = {3'b000, r[5:4]};
    case (k)
      0: w[6:0] = `OPC_LUI;
      1: w[6:0] = `OPC_AUIPC;
      2: w[6:0] = `OPC_JAL;
      3: begin
        w[6:0]   = `OPC_JALR;
        w[14:12] = 3'b000;
      end
      4: w[6:0] = `OPC_BRANCH;
      5: w[6:0] = `OPC_LOAD;
      6: w[6:0] = `OPC_STORE;
      7: begin
        w[6:0] = `OPC_OPIMM;
        if (r[6]) w[31:25] = {1'b0, r[7], 5'b00000};
      end
      8: begin
        w[6:0] = `OPC_OPREG;
        if (!r[9]) w[31:25] = {1'b0, r[7], 5'b00000};
      end
      9: w = (r[9:8] == 2'd0) ? `INST_ECALL : (r[9:8] == 2'd1) ? `INST_EBREAK : `INST_MRET;
      default: ;
    endcase
    return w;
  endfunction

  // called and returns 1 ns after a rising edge
  task automatic send(input logic [31:0] w, input logic v, input logic fl);
    logic [31:0] r;
    int          n;
    r           = next_rand();
    inst_data   = w;
    inst_addr   = pc;
    valid       = v;
    flush       = fl;
    trap_in     = r[31:24];
    mem_rd_addr = {3'b000, r[1:0]};
    rs1_data    = next_rand();
    rs2_data    = next_rand();
    ex_data     = next_rand();
    mem_rd_data = next_rand();
    pc          = pc + 32'd4;
    #1;
    n = 0;
    // hold the word while a load ahead of it blocks
    while (v && !fl && stall && n < 8) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (v && !fl && stall) begin
      $display("Timeout at %0t ns: stall_o stayed high for the held instruction", $time);
      timeouts++;
    end
    @(posedge clk);
    #1;
  endtask

  initial begin
    int          k;
    logic [31:0] w;
    logic [31:0] d;
    logic [31:0] r;
    lcg_state   = 32'hd8f2a641;
    errors      = 0;
    timeouts    = 0;
    pc          = 32'h0000_1000;
    arst_n      = 1'b0;
    valid       = 1'b0;
    flush       = 1'b0;
    inst_addr   = '0;
    inst_data   = '0;
    trap_in     = '0;
    rs1_data    = '0;
    rs2_data    = '0;
    ex_data     = '0;
    mem_rd_addr = '0;
    mem_rd_data = '0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    send(`INST_ECALL, 1'b1, 1'b0);
    send(`INST_EBREAK, 1'b1, 1'b0);
    send(`INST_MRET, 1'b1, 1'b0);

    // lw followed by a reader of its rd
    for (int i = 0; i < 24; i++) begin
      w = make_inst(5);
      w[14:12] = 3'b010;
      w[11:7]  = {3'b000, i[1:0]} | 5'd1;
      send(w, 1'b1, 1'b0);
      d = make_inst(8);
      d[31:25] = 7'h00;
      if (i[0]) d[19:15] = w[11:7];
      else d[24:20] = w[11:7];
      send(d, 1'b1, 1'b0);
    end

    // random mix with idle slots and flush pulses
    for (int i = 0; i < 600; i++) begin
      r = next_rand();
      k = r % 32'd11;
      w = make_inst(k);
      send(w, r[31:28] != 4'd0, r[27:24] == 4'd0);
    end

    valid = 1'b0;
    flush = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    $display("Run finished with %0d mismatches and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+src
src/decode_pkg.sv
src/inst_classifier.sv
src/imm_gen.sv
src/operand_bypass.sv
src/id_ex_reg.sv
src/decode_stage.sv
verification/decode_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert --timescale 1ns/10ps
TOP       := decode_stage_tb
RTL_TOP   := decode_stage
FILELIST  := files.f
OBJDIR    := obj_dir
SIM_BIN   := sim_$(TOP)
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJDIR) -o $(SIM_BIN)
	./$(OBJDIR)/$(SIM_BIN) | tee $(LOG)
	grep -qx "All checks passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
